/* qla_ctrl.f */
common/qla_bus_pkg.sv
common/qla_chan_pkg.sv
common/reg_bus_if.sv
src/bus_decode.sv
qla_channels/chan_execute.sv
src/read_result.sv
src/qla_ctrl.sv
test/qla_checker.sv
test/tb_qla_ctrl.sv

/* test/tb_qla_ctrl.sv */
// Random APB and quadrature stimulus with a register and encoder model
// Encoder inputs held 6 cycles per step to cover the 3-cycle sync path

`timescale 1ns/10ps

module tb_qla_ctrl;

    localparam int N_RW   = 64;    // Random valid register transfers
    localparam int N_STEP = 48;    // Quadrature steps with 4 encoder reads each
    localparam int N_BAD  = 32;    // Mostly erroring transfers
    // Two sweeps of 10 reads, preload allowance per step, 2 fixed error writes
    localparam int N_XFER = 20 + N_RW + N_STEP * 5 + N_BAD + 2;
    localparam int TIMEOUT_CYC = (16 + N_XFER * 2 + N_STEP * 6) * 3 / 2;

    logic        sysclk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  board_id;
    logic [3:0]  enc_a;
    logic [3:0]  enc_b;
    logic [63:0] dac_value;
    logic [3:0]  amp_enable;

    // Reference model
    logic [63:0] m_dac;            // Same layout as dac_value
    logic [3:0]  m_power;
    logic [23:0] m_enc [4];
    logic [1:0]  m_pos [4];        // Gray position index 0 to 3
    logic [31:0] exp_rdata;
    logic        exp_err;
    int          n_xfer;
    int          n_count_err;
    int          n_rdata_err;
    int          n_slverr_err;
    int          n_port_err;
    int          n_stall;
    int          n_access;

    qla_ctrl uut (
        .sysclk(sysclk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .board_id(board_id), .enc_a(enc_a), .enc_b(enc_b),
        .dac_value(dac_value), .amp_enable(amp_enable)
    );

    qla_checker chk (
        .sysclk(sysclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .dac_value(dac_value), .amp_enable(amp_enable),
        .exp_err(exp_err), .exp_rdata(exp_rdata), .exp_dac(m_dac), .exp_amp(m_power),
        .n_rdata_err(n_rdata_err), .n_slverr_err(n_slverr_err), .n_port_err(n_port_err),
        .n_stall(n_stall), .n_access(n_access)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 50 MHz
    end

    function automatic logic [15:0] chan_addr(input int ch, input logic [3:0] dev);
        return {qla_bus_pkg::SPACE_CHAN, 4'd0, 4'(ch), dev};
    endfunction

    // {error, read word} for an access under the register map rules
    function automatic logic [32:0] expect_access(input logic wr, input logic [15:0] a);
        logic [31:0] data;
        int          ch;
        data = '0;
        ch   = a[7:4];
        if (a[15:12] == qla_bus_pkg::SPACE_BOARD && a[11:0] == qla_bus_pkg::BREG_STATUS
            && !wr) begin
            data[31:24] = qla_chan_pkg::STATUS_VER;
            data[11:8]  = 4'(qla_chan_pkg::NUM_CHAN);
            data[3:0]   = board_id;
            return {1'b0, data};
        end
        if (a[15:12] == qla_bus_pkg::SPACE_BOARD && a[11:0] == qla_bus_pkg::BREG_POWER)
            return {1'b0, 28'd0, m_power};
        if (a[15:12] == qla_bus_pkg::SPACE_CHAN && a[11:8] == 4'd0
            && ch < qla_chan_pkg::NUM_CHAN) begin
            if (a[3:0] == qla_chan_pkg::DEV_DAC)
                return {17'd0, m_dac[ch*16 +: 16]};
            if (a[3:0] == qla_chan_pkg::DEV_ENC)
                return {1'b0, {8{m_enc[ch][23]}}, m_enc[ch]};   // Signed count
        end
        return {1'b1, 32'd0};   // Undefined, read only or channel out of range
    endfunction

    // Valid writes only
    task automatic model_write(input logic [15:0] a, input logic [31:0] d);
        int ch;
        ch = a[7:4];
        if (a[15:12] == qla_bus_pkg::SPACE_BOARD)
            m_power = d[3:0];
        else if (a[3:0] == qla_chan_pkg::DEV_DAC)
            m_dac[ch*16 +: 16] = d[15:0];
        else
            m_enc[ch] = d[23:0];               // Preload
    endtask

    // Setup and access phases driven 2 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [31:0] d);
        logic [32:0] resp;
        resp    = expect_access(wr, a);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge sysclk);
        #2;
        penable   = 1'b1;
        exp_err   = resp[32];
        exp_rdata = resp[31:0];
        @(negedge sysclk);
        while (pready !== 1'b1)                // Wait states stretch the access
            @(negedge sysclk);
        @(posedge sysclk);                     // Access ends on this edge
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        n_xfer++;
        if (wr && !resp[32])
            model_write(a, d);   // DUT took it on the edge just passed
    endtask

    task automatic read_all();
        apb_xfer(1'b0, {qla_bus_pkg::SPACE_BOARD, qla_bus_pkg::BREG_STATUS}, 32'd0);
        apb_xfer(1'b0, {qla_bus_pkg::SPACE_BOARD, qla_bus_pkg::BREG_POWER}, 32'd0);
        for (int ch = 0; ch < 4; ch++) begin
            apb_xfer(1'b0, chan_addr(ch, qla_chan_pkg::DEV_DAC), 32'd0);
            apb_xfer(1'b0, chan_addr(ch, qla_chan_pkg::DEV_ENC), 32'd0);
        end
    endtask

    task automatic random_reg_xfer();
        logic        wr;
        logic [15:0] a;
        int          ch;
        wr = 1'($urandom_range(0, 1));
        ch = $urandom_range(0, 3);
        case ($urandom_range(0, 3))
            0: begin
                a  = {qla_bus_pkg::SPACE_BOARD, qla_bus_pkg::BREG_STATUS};
                wr = 1'b0;                     // Keep this one legal
            end
            1:       a = {qla_bus_pkg::SPACE_BOARD, qla_bus_pkg::BREG_POWER};
            2:       a = chan_addr(ch, qla_chan_pkg::DEV_DAC);
            default: a = chan_addr(ch, qla_chan_pkg::DEV_ENC);
        endcase
        apb_xfer(wr, a, $urandom);
    endtask

    task automatic bad_xfer();
        logic [15:0] a;
        a = 16'($urandom);
        if ($urandom_range(0, 1))
            a[15:13] = 3'b000;                 // Board or channel space with odd index
        apb_xfer(1'($urandom_range(0, 1)), a, $urandom);
    endtask

    // Forward counts up (A leads B), backward down, double flip ignored
    task automatic quad_step();
        int act;
        for (int ch = 0; ch < 4; ch++) begin
            act = $urandom_range(0, 4);
            if (act < 2) begin
                m_pos[ch] = m_pos[ch] + 2'd1;
                m_enc[ch] = m_enc[ch] + 24'd1;
            end else if (act < 4) begin
                m_pos[ch] = m_pos[ch] - 2'd1;
                m_enc[ch] = m_enc[ch] - 24'd1;
            end else begin
                m_pos[ch] = m_pos[ch] + 2'd2;  // Both lines flip
            end
            enc_a[ch] = ^m_pos[ch];            // 00, 10, 11, 01 as A,B
            enc_b[ch] = m_pos[ch][1];
        end
        repeat (6) @(posedge sysclk);
        #2;
    endtask

    task automatic print_counts();
        $display("Errors: prdata %0d, pslverr %0d, ports %0d, stalls %0d, transfer count %0d",
                 n_rdata_err, n_slverr_err, n_port_err, n_stall, n_count_err);
    endtask

    initial begin
        void'($urandom(32'he327));
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        enc_a    = '0;
        enc_b    = '0;
        board_id = 4'($urandom);
        m_dac    = '0;
        m_power  = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        n_xfer      = 0;
        n_count_err = 0;
        for (int ch = 0; ch < 4; ch++) begin
            m_enc[ch] = '0;
            m_pos[ch] = '0;
        end
        repeat (16) @(posedge sysclk);
        #2;
        rst = 1'b0;

        read_all();                            // Reset values
        for (int i = 0; i < N_RW; i++)
            random_reg_xfer();

        for (int s = 0; s < N_STEP; s++) begin
            // Occasional preload near the top of the range to force a wrap
            if (s % 8 == 0)
                apb_xfer(1'b1, chan_addr($urandom_range(0, 3), qla_chan_pkg::DEV_ENC),
                         (s % 16 == 0) ? 32'h00ff_fffe : $urandom);
            quad_step();
            for (int ch = 0; ch < 4; ch++)
                apb_xfer(1'b0, chan_addr(ch, qla_chan_pkg::DEV_ENC), 32'd0);
        end

        apb_xfer(1'b1, {qla_bus_pkg::SPACE_BOARD, qla_bus_pkg::BREG_STATUS}, $urandom);
        apb_xfer(1'b1, chan_addr(4, qla_chan_pkg::DEV_DAC), $urandom);
        for (int i = 0; i < N_BAD; i++)
            bad_xfer();
        read_all();                            // Nothing moved
        repeat (2) @(posedge sysclk);

        // Two cycles per transfer means one access cycle each
        if (n_access != n_xfer) begin
            n_count_err = 1;
            $display("Checker saw %0d access cycles for %0d transfers", n_access, n_xfer);
        end
        print_counts();
        if (n_rdata_err + n_slverr_err + n_port_err + n_stall + n_count_err == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge sysclk);
        $display("Watchdog expired after %0d cycles, stimulus did not finish", TIMEOUT_CYC);
        print_counts();
        $display("Done: errors found");
        $finish;
    end

endmodule

/* test/qla_checker.sv */
// Checks APB completions and motor ports against the model in the testbench
// Samples on the falling edge, clear of input drive and register updates
// prdata is only compared on reads

`timescale 1ns/10ps

module qla_checker (
    input  logic        sysclk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic        pready,
    input  logic        pslverr,
    input  logic [31:0] prdata,
    input  logic [63:0] dac_value,
    input  logic [3:0]  amp_enable,
    input  logic        exp_err,       // Model response for current access
    input  logic [31:0] exp_rdata,
    input  logic [63:0] exp_dac,       // Model register state
    input  logic [3:0]  exp_amp,
    output int          n_rdata_err,
    output int          n_slverr_err,
    output int          n_port_err,
    output int          n_stall,
    output int          n_access       // Completed access cycles
);

    initial begin
        n_rdata_err  = 0;
        n_slverr_err = 0;
        n_port_err   = 0;
        n_stall      = 0;
        n_access     = 0;
    end

    always @(negedge sysclk) begin
        if (!rst) begin
            if (psel && penable) begin
                n_access++;
                // Zero wait states, so a low pready would hang the transfer
                if (pready !== 1'b1) begin
                    n_stall++;
                    $display("Transfer stalled at %0d ns: pready low in access cycle", $time);
                end
                if (pslverr !== exp_err) begin
                    n_slverr_err++;
                    $display("Error at %0d ns: pslverr expected %b got %b",
                             $time, exp_err, pslverr);
                end
                if (!pwrite && (prdata !== exp_rdata)) begin
                    n_rdata_err++;
                    $display("Error at %0d ns: prdata expected %h got %h",
                             $time, exp_rdata, prdata);
                end
            end else if (pslverr !== 1'b0) begin   // Only in access cycles
                n_slverr_err++;
                $display("Error at %0d ns: pslverr expected 0 got %b", $time, pslverr);
            end
            if (dac_value !== exp_dac) begin
                n_port_err++;
                $display("Error at %0d ns: dac_value expected %h got %h",
                         $time, exp_dac, dac_value);
            end
            if (amp_enable !== exp_amp) begin
                n_port_err++;
                $display("Error at %0d ns: amp_enable expected %h got %h",
                         $time, exp_amp, amp_enable);
            end
        end
    end

endmodule

/* src/qla_ctrl.sv */
// Motor controller register subsystem, APB slave with zero wait states
// Encoder inputs are asynchronous; synchronized inside chan_execute

`timescale 1ns/10ps

module qla_ctrl (
    input  logic                                               sysclk,
    input  logic                                               rst,
    // APB slave
    input  logic                                               psel,
    input  logic                                               penable,
    input  logic                                               pwrite,
    input  logic [qla_bus_pkg::ADDR_W-1:0]                     paddr,
    input  logic [qla_bus_pkg::DATA_W-1:0]                     pwdata,
    output logic [qla_bus_pkg::DATA_W-1:0]                     prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    // Board and motor I/O
    input  logic [3:0]                                         board_id,   // Rotary switch
    input  logic [qla_chan_pkg::NUM_CHAN-1:0]                  enc_a,
    input  logic [qla_chan_pkg::NUM_CHAN-1:0]                  enc_b,
    output logic [qla_chan_pkg::NUM_CHAN*qla_chan_pkg::DAC_W-1:0] dac_value, // Ch 0 lowest
    output logic [qla_chan_pkg::NUM_CHAN-1:0]                  amp_enable
);

    reg_bus_if regbus ();   // Shared register bus

    // APB front end, address decode and write strobe
    bus_decode decode (
        .sysclk (sysclk),
        .rst    (rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .pready (pready),
        .pslverr(pslverr),
        .bus    (regbus.decode)
    );

    // Register state and encoders
    chan_execute execute (
        .sysclk    (sysclk),
        .rst       (rst),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .dac_value (dac_value),
        .amp_enable(amp_enable),
        .bus       (regbus.execute)
    );

    read_result result (
        .board_id(board_id),
        .bus     (regbus.result)
    );

    assign prdata = regbus.rdata;   // Read word straight to APB

endmodule

/* src/read_result.sv */
// Read mux, combinational during the access cycle
// Misses and invalid registers read as 0; pslverr itself comes from bus_decode

`timescale 1ns/10ps

module read_result (
    input  logic [3:0] board_id,
    reg_bus_if.result  bus
);

    localparam int DATA_W = qla_bus_pkg::DATA_W;
    localparam int ENC_W  = qla_chan_pkg::ENC_W;

    logic [qla_chan_pkg::CHAN_SEL_W-1:0] ch_sel;
    logic [ENC_W-1:0]                    enc_word;
    logic [DATA_W-1:0]                   status_word;

    assign ch_sel   = bus.addr.chan.channel[qla_chan_pkg::CHAN_SEL_W-1:0];
    assign enc_word = bus.enc_cnt[ch_sel];

    // Version | zeros | channel count | zeros | board id
    assign status_word = {qla_chan_pkg::STATUS_VER,
                          12'd0,
                          4'(qla_chan_pkg::NUM_CHAN),
                          4'd0,
                          board_id};

    always_comb begin
        bus.rdata = '0;                                 // Default on miss
        if (bus.board_hit && bus.dev_ok) begin
            case (bus.addr.board.reg_idx)
                qla_bus_pkg::BREG_STATUS: bus.rdata = status_word;
                qla_bus_pkg::BREG_POWER:  bus.rdata = DATA_W'(bus.power_mask);
                default:                  bus.rdata = '0;
            endcase
        end else if (bus.chan_hit && bus.dev_ok) begin
            case (bus.addr.chan.dev)
                qla_chan_pkg::DEV_DAC: bus.rdata = DATA_W'(bus.dac_reg[ch_sel]);
                // Encoder count is signed
                qla_chan_pkg::DEV_ENC: bus.rdata = {{(DATA_W-ENC_W){enc_word[ENC_W-1]}},
                                                    enc_word};
                default:               bus.rdata = '0;
            endcase
        end
    end

endmodule

/* qla_channels/chan_execute.sv */
// Board and channel register state, quadrature decode per channel
// Encoder path is 2 sync flops and an edge stage, so a count lands 3 cycles after input

`timescale 1ns/10ps

module chan_execute (
    input  logic                                                   sysclk,
    input  logic                                                   rst,
    input  logic [qla_chan_pkg::NUM_CHAN-1:0]                      enc_a,
    input  logic [qla_chan_pkg::NUM_CHAN-1:0]                      enc_b,
    output logic [qla_chan_pkg::NUM_CHAN*qla_chan_pkg::DAC_W-1:0]  dac_value,
    output logic [qla_chan_pkg::NUM_CHAN-1:0]                      amp_enable,
    reg_bus_if.execute                                             bus
);

    localparam int NCH = qla_chan_pkg::NUM_CHAN;

    logic [NCH-1:0] a_s1, a_s2, a_prev;     // Channel A sync chain
    logic [NCH-1:0] b_s1, b_s2, b_prev;     // Channel B sync chain
    logic [NCH-1:0] step;                   // Single legal Gray transition
    logic [NCH-1:0] up;                     // Direction of that step

    logic [NCH-1:0]                          power_q;
    logic [NCH-1:0][qla_chan_pkg::DAC_W-1:0] dac_q;
    logic [NCH-1:0][qla_chan_pkg::ENC_W-1:0] enc_q;

    logic                                  power_wr;
    logic                                  chan_wr;
    logic [qla_chan_pkg::CHAN_SEL_W-1:0]   ch_sel;

    // Write decode from the strobe qualified in bus_decode
    assign power_wr = bus.wr_en & bus.board_hit &
                      (bus.addr.board.reg_idx == qla_bus_pkg::BREG_POWER);
    assign chan_wr  = bus.wr_en & bus.chan_hit;
    assign ch_sel   = bus.addr.chan.channel[qla_chan_pkg::CHAN_SEL_W-1:0];

    always_ff @(posedge sysclk) begin
        if (rst) begin
            power_q <= '0;
        end else if (power_wr) begin
            power_q <= bus.wdata[NCH-1:0];  // One enable bit per amp
        end
    end

    // Two sync flops per input, then the edge-detect stage
    always_ff @(posedge sysclk) begin
        a_s1   <= enc_a;
        a_s2   <= a_s1;
        a_prev <= a_s2;
        b_s1   <= enc_b;
        b_s2   <= b_s1;
        b_prev <= b_s2;
    end

    for (genvar ch = 0; ch < NCH; ch++) begin : g_chan
        logic dac_wr;
        logic enc_wr;

        assign dac_wr = chan_wr && (ch_sel == qla_chan_pkg::CHAN_SEL_W'(ch)) &&
                        (bus.addr.chan.dev == qla_chan_pkg::DEV_DAC);
        assign enc_wr = chan_wr && (ch_sel == qla_chan_pkg::CHAN_SEL_W'(ch)) &&
                        (bus.addr.chan.dev == qla_chan_pkg::DEV_ENC);

        // Exactly one of A/B moved; both moving is an illegal jump
        assign step[ch] = (a_s2[ch] ^ a_prev[ch]) ^ (b_s2[ch] ^ b_prev[ch]);
        assign up[ch]   = a_s2[ch] ^ b_prev[ch];   // A leads B

        always_ff @(posedge sysclk) begin
            if (rst) begin
                dac_q[ch] <= '0;
            end else if (dac_wr) begin
                dac_q[ch] <= bus.wdata[qla_chan_pkg::DAC_W-1:0];
            end
        end

        // Preload beats a count step in the same cycle
        always_ff @(posedge sysclk) begin
            if (rst) begin
                enc_q[ch] <= '0;
            end else if (enc_wr) begin
                enc_q[ch] <= bus.wdata[qla_chan_pkg::ENC_W-1:0];
            end else if (step[ch]) begin
                if (up[ch]) begin
                    enc_q[ch] <= enc_q[ch] + qla_chan_pkg::ENC_W'(1);  // Wraps mod 2^24
                end else begin
                    enc_q[ch] <= enc_q[ch] - qla_chan_pkg::ENC_W'(1);
                end
            end
        end
    end

    // Ports follow registers directly
    assign amp_enable = power_q;
    assign dac_value  = dac_q;          // Ch 0 in low bits

    // State back to the bus for reads
    assign bus.power_mask = power_q;
    assign bus.dac_reg    = dac_q;
    assign bus.enc_cnt    = enc_q;

endmodule

/* src/bus_decode.sv */
// APB slave decode; pready tied high, every transfer is setup plus one access
// pslverr on undefined address, status write or channel >= NUM_CHAN

`timescale 1ns/10ps

module bus_decode (
    input  logic                           sysclk,
    input  logic                           rst,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [qla_bus_pkg::ADDR_W-1:0] paddr,
    input  logic [qla_bus_pkg::DATA_W-1:0] pwdata,
    output logic                           pready,
    output logic                           pslverr,
    reg_bus_if.decode                      bus
);

    qla_bus_pkg::reg_addr_u addr;   // paddr seen both ways
    logic setup_q;                  // Previous cycle was a setup phase
    logic access;                   // Qualified access phase
    logic board_hit;
    logic chan_hit;
    logic dev_ok;
    logic valid;                    // Access may complete without error

    assign addr = paddr;

    // Track setup phase so penable held high cannot repeat a write
    always_ff @(posedge sysclk) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel & ~penable;
        end
    end

    assign access = psel & penable & setup_q;

    // Space decode
    assign board_hit = (addr.board.space == qla_bus_pkg::SPACE_BOARD);
    assign chan_hit  = (addr.chan.space == qla_bus_pkg::SPACE_CHAN) &&
                       (addr.chan.unused == 4'd0) &&
                       (addr.chan.channel < qla_chan_pkg::NUM_CHAN);  // Channel range

    // Register / device existence
    always_comb begin
        dev_ok = 1'b0;
        if (board_hit) begin
            case (addr.board.reg_idx)
                qla_bus_pkg::BREG_STATUS: dev_ok = ~pwrite;   // Read only
                qla_bus_pkg::BREG_POWER:  dev_ok = 1'b1;
                default:                  dev_ok = 1'b0;
            endcase
        end else if (chan_hit) begin
            // Both channel devices are read/write
            dev_ok = (addr.chan.dev == qla_chan_pkg::DEV_DAC) ||
                     (addr.chan.dev == qla_chan_pkg::DEV_ENC);
        end
    end

    assign valid = (board_hit | chan_hit) & dev_ok;

    // APB response, no wait states
    assign pready  = 1'b1;
    assign pslverr = access & ~valid;

    // Register bus drive
    assign bus.wr_en     = access & pwrite & valid;   // Lands on edge ending access
    assign bus.addr      = addr;
    assign bus.wdata     = pwdata;
    assign bus.board_hit = board_hit;
    assign bus.chan_hit  = chan_hit;
    assign bus.dev_ok    = dev_ok;

endmodule

/* common/reg_bus_if.sv */
// Internal register bus between APB decode, register execute and read result
// Hit and dev_ok flags are combinational from the current APB address

`timescale 1ns/10ps

interface reg_bus_if;

    logic                                  wr_en;      // One-cycle write strobe
    qla_bus_pkg::reg_addr_u                addr;       // Decoded address
    logic [qla_bus_pkg::DATA_W-1:0]        wdata;      // Write data
    logic                                  board_hit;  // Board space
    logic                                  chan_hit;   // Channel space, channel in range
    logic                                  dev_ok;     // Register exists (and writable on write)
    logic [qla_bus_pkg::DATA_W-1:0]        rdata;      // Read word, 0 on miss

    // Register state exported by execute
    logic [qla_chan_pkg::NUM_CHAN-1:0]                         power_mask;
    logic [qla_chan_pkg::NUM_CHAN-1:0][qla_chan_pkg::DAC_W-1:0] dac_reg;
    logic [qla_chan_pkg::NUM_CHAN-1:0][qla_chan_pkg::ENC_W-1:0] enc_cnt;

    modport decode (output wr_en, addr, wdata, board_hit, chan_hit, dev_ok);

    modport execute (input wr_en, addr, wdata, board_hit, chan_hit,
                     output power_mask, dac_reg, enc_cnt);

    modport result (input addr, board_hit, chan_hit, dev_ok,
                    input power_mask, dac_reg, enc_cnt,
                    output rdata);

endinterface

/* common/qla_chan_pkg.sv */
// Channel geometry and device offsets
// NUM_CHAN must stay a power of two for the channel select width

package qla_chan_pkg;

    localparam int NUM_CHAN   = 4;                    // Motor channels
    localparam int CHAN_SEL_W = $clog2(NUM_CHAN);     // Bits to pick a channel

    // Device offsets inside a channel
    localparam logic [3:0] DEV_DAC = 4'd0;            // DAC command
    localparam logic [3:0] DEV_ENC = 4'd1;            // Encoder counter, preloadable

    localparam int DAC_W = 16;                        // DAC command width
    localparam int ENC_W = 24;                        // Encoder counter width

    // Firmware version in status[31:24]
    localparam logic [7:0] STATUS_VER = 8'h51;

endpackage

/* common/qla_bus_pkg.sv */
// Register bus address layout for the motor controller register space
// Space field in addr[15:12]; only board and channel spaces are decoded
// Board space has just two registers; all other indices are undefined

package qla_bus_pkg;

    localparam int ADDR_W = 16;                 // APB address width
    localparam int DATA_W = 32;                 // APB data width

    // Address space select, addr[15:12]
    localparam logic [3:0] SPACE_BOARD = 4'd0;  // Board registers
    localparam logic [3:0] SPACE_CHAN  = 4'd1;  // Per-channel devices

    // Board view of the address word
    typedef struct packed {
        logic [3:0]  space;                     // Address space
        logic [11:0] reg_idx;                   // Board register index
    } board_addr_t;

    // Channel view of the same word
    typedef struct packed {
        logic [3:0] space;                      // Address space
        logic [3:0] unused;                     // Must be zero for a hit
        logic [3:0] channel;                    // Channel number
        logic [3:0] dev;                        // Device offset in channel
    } chan_addr_t;

    // One address word, two decodes
    typedef union packed {
        board_addr_t board;
        chan_addr_t  chan;
    } reg_addr_u;

    // Board register indices
    localparam logic [11:0] BREG_STATUS = 12'd0;   // Read only
    localparam logic [11:0] BREG_POWER  = 12'd1;   // Amp power mask, read/write

endpackage
